//--- src/lce_pkg.sv
// lce request side definitions
`default_nettype none

package lce_pkg;

  // sizing
  localparam int paddr_width = 32;
  localparam int dword_width = 64;
  localparam int block_width = 512;
  localparam int lce_assoc = 8;
  localparam int lg_assoc = $clog2(lce_assoc);
  localparam int num_cce = 2;
  localparam int lg_num_cce = $clog2(num_cce);
  localparam int lce_id_width = 2;
  localparam int max_credits = 4;
  localparam int credit_width = 3;
  localparam int fifo_els = 4;
  localparam int lg_fifo_els = $clog2(fifo_els);

  // miss loads go out non-exclusive when set
  localparam bit non_excl_reads = 1'b0;

  // cce select bits sit just above the 64 byte block offset
  localparam int cce_id_shift = 6;

  typedef enum logic [1:0] {miss_load, miss_store, uc_load, uc_store} cache_req_type_e;

  typedef enum logic [2:0] {
    msg_size_1, msg_size_2, msg_size_4, msg_size_8,
    msg_size_16, msg_size_32, msg_size_64
  } msg_size_e;

  typedef enum logic {lce_mode_normal, lce_mode_uncached} lce_mode_e;

  typedef enum logic [1:0] {rd, wr, uc_rd, uc_wr} req_msg_type_e;

  // size of a cached request follows the block width
  localparam msg_size_e req_block_size =
    (block_width / 8 == 64) ? msg_size_64 :
    (block_width / 8 == 32) ? msg_size_32 : msg_size_16;

  typedef struct packed {
    req_msg_type_e msg_type;
    msg_size_e size;
    logic [paddr_width-1:0] addr;
    logic [lce_id_width-1:0] src_id;
    logic [lg_num_cce-1:0] dst_id;
    logic [lg_assoc-1:0] lru_way;
    logic non_exclusive;
    logic [dword_width-1:0] data;
  } lce_req_msg_s;

  typedef struct packed {
    cache_req_type_e msg_type;
    msg_size_e size;
    logic [paddr_width-1:0] addr;
    logic [dword_width-1:0] data;
  } cache_req_s;

  typedef struct packed {
    logic [lg_assoc-1:0] repl_way;
  } cache_meta_s;

  typedef enum logic [1:0] {st_reset, st_ready, st_send_cached, st_send_uncached} lce_req_state_e;

  typedef enum logic [1:0] {eng_idle, eng_cmd, eng_resp} cce_engine_state_e;

endpackage

`default_nettype wire

//--- src/lce_req_if.sv
// coherence request channel
`default_nettype none

interface lce_req_if
  import lce_pkg::*;
();

  // ready comes first, valid only while ready is high
  lce_req_msg_s msg;
  logic valid;
  logic ready;

  modport sender (
    output msg,
    output valid,
    input ready
  );

  modport receiver (
    input msg,
    input valid,
    output ready
  );

endinterface

`default_nettype wire

//--- src/lce_req.sv
// lce request handler
`default_nettype none

module lce_req
  import lce_pkg::*;
(
  input wire logic clk_i,
  input wire logic reset_i,

  input wire logic [lce_id_width-1:0] lce_id_i,
  input wire lce_mode_e lce_mode_i,
  input wire logic sync_done_i,

  input wire cache_req_s cache_req_i,
  input wire logic cache_req_v_i,
  input wire cache_meta_s cache_meta_i,
  input wire logic cache_meta_v_i,

  output logic ready_o,
  output logic credits_full_o,
  output logic credits_empty_o,

  input wire logic req_complete_i,
  input wire logic uc_store_complete_i,

  lce_req_if.sender req_o
);

  lce_req_state_e state_r, state_n;

  cache_req_s cache_req_r;
  cache_meta_s cache_meta_r;
  logic meta_v_r;

  logic [credit_width-1:0] credit_r;
  logic credit_inc;
  logic credit_dec;

  logic [paddr_width-1:0] req_addr;
  logic [lg_num_cce-1:0] req_cce_id;

  lce_req_msg_s msg;
  logic msg_v;

  // request and metadata capture
  always_ff @(posedge clk_i) begin
    if (cache_req_v_i) begin
      cache_req_r <= cache_req_i;
    end
    if (cache_meta_v_i) begin
      cache_meta_r <= cache_meta_i;
    end
  end

  // a new request clears the metadata flag but metadata in the same cycle wins
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      meta_v_r <= 1'b0;
    end else if (cache_meta_v_i) begin
      meta_v_r <= 1'b1;
    end else if (cache_req_v_i) begin
      meta_v_r <= 1'b0;
    end
  end

  // outstanding requests
  assign credit_inc = msg_v;
  assign credit_dec = req_complete_i | uc_store_complete_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credit_r <= '0;
    end else begin
      credit_r <= credit_r + credit_width'(credit_inc) - credit_width'(credit_dec);
    end
  end

  assign credits_full_o = (credit_r == credit_width'(max_credits));
  assign credits_empty_o = (credit_r == '0);

  // uc stores leave straight from the input, everything else from the register
  assign req_addr = (state_r == st_ready) ? cache_req_i.addr : cache_req_r.addr;
  assign req_cce_id = req_addr[cce_id_shift +: lg_num_cce];

  always_comb begin
    state_n = state_r;
    ready_o = 1'b0;
    msg_v = 1'b0;

    msg = '0;
    msg.src_id = lce_id_i;
    msg.dst_id = req_cce_id;

    unique case (state_r)
      st_reset: begin
        state_n = st_ready;
      end

      st_ready: begin
        ready_o = ~credits_full_o & req_o.ready
                  & ((lce_mode_i == lce_mode_uncached) | sync_done_i);
        if (cache_req_v_i) begin
          unique case (cache_req_i.msg_type)
            miss_load, miss_store: begin
              state_n = st_send_cached;
            end
            uc_load: begin
              state_n = st_send_uncached;
            end
            uc_store: begin
              msg_v = req_o.ready;
              msg.msg_type = uc_wr;
              msg.size = cache_req_i.size;
              msg.addr = cache_req_i.addr;
              msg.data = cache_req_i.data;
            end
            default: begin
            end
          endcase
        end
      end

      st_send_cached: begin
        // wait for both the channel and the replacement way
        msg_v = req_o.ready & meta_v_r;
        msg.msg_type = (cache_req_r.msg_type == miss_load) ? rd : wr;
        msg.size = req_block_size;
        msg.addr = cache_req_r.addr;
        msg.lru_way = cache_meta_r.repl_way;
        msg.non_exclusive = (cache_req_r.msg_type == miss_load) & non_excl_reads;
        if (msg_v) begin
          state_n = st_ready;
        end
      end

      st_send_uncached: begin
        msg_v = req_o.ready;
        msg.msg_type = uc_rd;
        msg.size = cache_req_r.size;
        msg.addr = cache_req_r.addr;
        if (msg_v) begin
          state_n = st_ready;
        end
      end

      default: begin
        state_n = st_reset;
      end
    endcase
  end

  assign req_o.msg = msg;
  assign req_o.valid = msg_v;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= st_reset;
    end else begin
      state_r <= state_n;
    end
  end

endmodule

`default_nettype wire

//--- src/lce_req_fifo.sv
// request message fifo
`default_nettype none

module lce_req_fifo
  import lce_pkg::*;
#(
  parameter type payload_t = lce_req_msg_s
) (
  input wire logic clk_i,
  input wire logic reset_i,

  lce_req_if.receiver enq_i,
  lce_req_if.sender deq_o
);

  payload_t mem_r [fifo_els];

  // pointers wrap on their own, depth is a power of two
  logic [lg_fifo_els-1:0] wr_ptr_r;
  logic [lg_fifo_els-1:0] rd_ptr_r;
  logic [lg_fifo_els:0] count_r;

  logic enq_fire;
  logic deq_fire;

  assign enq_i.ready = (count_r != (lg_fifo_els + 1)'(fifo_els));
  assign deq_o.valid = (count_r != '0);
  assign deq_o.msg = mem_r[rd_ptr_r];

  assign enq_fire = enq_i.valid & enq_i.ready;
  assign deq_fire = deq_o.valid & deq_o.ready;

  always_ff @(posedge clk_i) begin
    if (enq_fire) begin
      mem_r[wr_ptr_r] <= enq_i.msg;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r <= '0;
    end else begin
      if (enq_fire) begin
        wr_ptr_r <= wr_ptr_r + 1'b1;
      end
      if (deq_fire) begin
        rd_ptr_r <= rd_ptr_r + 1'b1;
      end
      // simultaneous read and write leaves the count alone
      count_r <= count_r + (lg_fifo_els + 1)'(enq_fire) - (lg_fifo_els + 1)'(deq_fire);
    end
  end

endmodule

`default_nettype wire

//--- src/lce_cce_engine.sv
// simplified cce engine
`default_nettype none

module lce_cce_engine
  import lce_pkg::*;
(
  input wire logic clk_i,
  input wire logic reset_i,

  lce_req_if.receiver req_i,

  output req_msg_type_e mem_cmd_type_o,
  output logic [paddr_width-1:0] mem_cmd_addr_o,
  output msg_size_e mem_cmd_size_o,
  output logic [lg_num_cce-1:0] mem_cmd_cce_id_o,
  output logic [lg_assoc-1:0] mem_cmd_way_o,
  output logic mem_cmd_non_excl_o,
  output logic [dword_width-1:0] mem_cmd_data_o,
  output logic mem_cmd_v_o,
  input wire logic mem_cmd_ready_i,
  input wire logic mem_resp_v_i,

  output logic req_complete_o,
  output logic uc_store_complete_o
);

  cce_engine_state_e state_r;
  lce_req_msg_s msg_r;
  logic done_r;
  logic take;

  assign req_i.ready = (state_r == eng_idle);
  assign take = req_i.valid & req_i.ready;

  always_ff @(posedge clk_i) begin
    if (take) begin
      msg_r <= req_i.msg;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= eng_idle;
      done_r <= 1'b0;
    end else begin
      done_r <= 1'b0;
      unique case (state_r)
        eng_idle: begin
          if (take) begin
            state_r <= eng_cmd;
          end
        end
        eng_cmd: begin
          if (mem_cmd_ready_i) begin
            state_r <= eng_resp;
          end
        end
        eng_resp: begin
          // completion pulses one cycle after the response
          if (mem_resp_v_i) begin
            done_r <= 1'b1;
            state_r <= eng_idle;
          end
        end
        default: begin
          state_r <= eng_idle;
        end
      endcase
    end
  end

  assign mem_cmd_v_o = (state_r == eng_cmd);
  assign mem_cmd_type_o = msg_r.msg_type;
  assign mem_cmd_addr_o = msg_r.addr;
  assign mem_cmd_size_o = msg_r.size;
  assign mem_cmd_cce_id_o = msg_r.dst_id;
  assign mem_cmd_way_o = msg_r.lru_way;
  assign mem_cmd_non_excl_o = msg_r.non_exclusive;
  assign mem_cmd_data_o = msg_r.data;

  // msg_r still holds the finished request while done_r is high
  assign uc_store_complete_o = done_r & (msg_r.msg_type == uc_wr);
  assign req_complete_o = done_r & (msg_r.msg_type != uc_wr);

endmodule

`default_nettype wire

//--- src/lce_top.sv
// lce request subsystem top
`default_nettype none

module lce_top
  import lce_pkg::*;
(
  input wire logic clk_i,
  input wire logic reset_i,

  input wire logic [lce_id_width-1:0] lce_id_i,
  input wire lce_mode_e lce_mode_i,
  input wire logic sync_done_i,

  input wire cache_req_type_e cache_req_type_i,
  input wire msg_size_e cache_req_size_i,
  input wire logic [paddr_width-1:0] cache_req_addr_i,
  input wire logic [dword_width-1:0] cache_req_data_i,
  input wire logic cache_req_v_i,
  input wire logic [lg_assoc-1:0] cache_meta_way_i,
  input wire logic cache_meta_v_i,

  output logic ready_o,
  output logic credits_full_o,
  output logic credits_empty_o,

  output req_msg_type_e mem_cmd_type_o,
  output logic [paddr_width-1:0] mem_cmd_addr_o,
  output msg_size_e mem_cmd_size_o,
  output logic [lg_num_cce-1:0] mem_cmd_cce_id_o,
  output logic [lg_assoc-1:0] mem_cmd_way_o,
  output logic mem_cmd_non_excl_o,
  output logic [dword_width-1:0] mem_cmd_data_o,
  output logic mem_cmd_v_o,
  input wire logic mem_cmd_ready_i,
  input wire logic mem_resp_v_i
);

  cache_req_s cache_req;
  cache_meta_s cache_meta;
  logic req_complete;
  logic uc_store_complete;

  lce_req_if req_enq ();
  lce_req_if req_deq ();

  assign cache_req = '{
    msg_type: cache_req_type_i,
    size: cache_req_size_i,
    addr: cache_req_addr_i,
    data: cache_req_data_i
  };
  assign cache_meta = '{repl_way: cache_meta_way_i};

  lce_req lce_req_inst (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .lce_id_i(lce_id_i),
    .lce_mode_i(lce_mode_i),
    .sync_done_i(sync_done_i),
    .cache_req_i(cache_req),
    .cache_req_v_i(cache_req_v_i),
    .cache_meta_i(cache_meta),
    .cache_meta_v_i(cache_meta_v_i),
    .ready_o(ready_o),
    .credits_full_o(credits_full_o),
    .credits_empty_o(credits_empty_o),
    .req_complete_i(req_complete),
    .uc_store_complete_i(uc_store_complete),
    .req_o(req_enq.sender)
  );

  lce_req_fifo #(
    .payload_t(lce_req_msg_s)
  ) lce_req_fifo_inst (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .enq_i(req_enq.receiver),
    .deq_o(req_deq.sender)
  );

  // completions flow back to the handler to return credits
  lce_cce_engine lce_cce_engine_inst (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .req_i(req_deq.receiver),
    .mem_cmd_type_o(mem_cmd_type_o),
    .mem_cmd_addr_o(mem_cmd_addr_o),
    .mem_cmd_size_o(mem_cmd_size_o),
    .mem_cmd_cce_id_o(mem_cmd_cce_id_o),
    .mem_cmd_way_o(mem_cmd_way_o),
    .mem_cmd_non_excl_o(mem_cmd_non_excl_o),
    .mem_cmd_data_o(mem_cmd_data_o),
    .mem_cmd_v_o(mem_cmd_v_o),
    .mem_cmd_ready_i(mem_cmd_ready_i),
    .mem_resp_v_i(mem_resp_v_i),
    .req_complete_o(req_complete),
    .uc_store_complete_o(uc_store_complete)
  );

endmodule

`default_nettype wire

//--- verif/tb_lce_top.sv
// lce request subsystem testbench
`default_nettype none

module tb_lce_top
  import lce_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_entries = 10;

  typedef struct packed {
    cache_req_type_e kind;
    logic [paddr_width-1:0] addr;
    msg_size_e size;
    logic [dword_width-1:0] data;
    logic [lg_assoc-1:0] way;
    logic [3:0] meta_delay;
    req_msg_type_e exp_type;
    msg_size_e exp_size;
    logic [lg_num_cce-1:0] exp_cce;
    logic exp_non_excl;
  } entry_s;

  logic clk_i = 1'b0;
  logic reset_i;
  logic [lce_id_width-1:0] lce_id_i;
  lce_mode_e lce_mode_i;
  logic sync_done_i;
  cache_req_type_e cache_req_type_i;
  msg_size_e cache_req_size_i;
  logic [paddr_width-1:0] cache_req_addr_i;
  logic [dword_width-1:0] cache_req_data_i;
  logic cache_req_v_i;
  logic [lg_assoc-1:0] cache_meta_way_i;
  logic cache_meta_v_i;
  logic ready_o;
  logic credits_full_o;
  logic credits_empty_o;
  req_msg_type_e mem_cmd_type_o;
  logic [paddr_width-1:0] mem_cmd_addr_o;
  msg_size_e mem_cmd_size_o;
  logic [lg_num_cce-1:0] mem_cmd_cce_id_o;
  logic [lg_assoc-1:0] mem_cmd_way_o;
  logic mem_cmd_non_excl_o;
  logic [dword_width-1:0] mem_cmd_data_o;
  logic mem_cmd_v_o;
  logic mem_cmd_ready_i;
  logic mem_resp_v_i;

  entry_s stim [num_entries];
  logic meta_given [num_entries];
  int cmd_count = 0;
  logic hold_ready = 1'b0;

  always #4 clk_i = ~clk_i;

  lce_top lce_top_inst (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .lce_id_i(lce_id_i),
    .lce_mode_i(lce_mode_i),
    .sync_done_i(sync_done_i),
    .cache_req_type_i(cache_req_type_i),
    .cache_req_size_i(cache_req_size_i),
    .cache_req_addr_i(cache_req_addr_i),
    .cache_req_data_i(cache_req_data_i),
    .cache_req_v_i(cache_req_v_i),
    .cache_meta_way_i(cache_meta_way_i),
    .cache_meta_v_i(cache_meta_v_i),
    .ready_o(ready_o),
    .credits_full_o(credits_full_o),
    .credits_empty_o(credits_empty_o),
    .mem_cmd_type_o(mem_cmd_type_o),
    .mem_cmd_addr_o(mem_cmd_addr_o),
    .mem_cmd_size_o(mem_cmd_size_o),
    .mem_cmd_cce_id_o(mem_cmd_cce_id_o),
    .mem_cmd_way_o(mem_cmd_way_o),
    .mem_cmd_non_excl_o(mem_cmd_non_excl_o),
    .mem_cmd_data_o(mem_cmd_data_o),
    .mem_cmd_v_o(mem_cmd_v_o),
    .mem_cmd_ready_i(mem_cmd_ready_i),
    .mem_resp_v_i(mem_resp_v_i)
  );

  function automatic logic [31:0] xorshift(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic is_cached(cache_req_type_e kind);
    return (kind == miss_load) || (kind == miss_store);
  endfunction

  // expected command fields follow the request kind
  function automatic entry_s make_entry(cache_req_type_e kind, logic [31:0] addr,
                                        msg_size_e size, logic [63:0] data,
                                        logic [2:0] way, logic [3:0] meta_delay);
    entry_s e;
    e.kind = kind;
    e.addr = addr;
    e.size = size;
    e.data = data;
    e.way = way;
    e.meta_delay = meta_delay;
    case (kind)
      miss_load: e.exp_type = rd;
      miss_store: e.exp_type = wr;
      uc_load: e.exp_type = uc_rd;
      default: e.exp_type = uc_wr;
    endcase
    // a cached request always moves a whole 64 byte block
    e.exp_size = is_cached(kind) ? msg_size_64 : size;
    e.exp_cce = addr[6];
    e.exp_non_excl = (kind == miss_load) && non_excl_reads;
    return e;
  endfunction

  task automatic stop_run(string what);
    $display("%s", what);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_type(string name, req_msg_type_e got, req_msg_type_e exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns %s: got %s expected %s", $time, name, got.name(), exp.name());
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_size(string name, msg_size_e got, msg_size_e exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns %s: got %s expected %s", $time, name, got.name(), exp.name());
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_vec(string name, logic [63:0] got, logic [63:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns %s: got 0x%0h expected 0x%0h", $time, name, got, exp);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_command(int idx);
    entry_s e;
    if (idx >= num_entries) begin
      stop_run("a memory command appeared after every table entry was served");
    end
    e = stim[idx];
    check_type("mem_cmd_type_o", mem_cmd_type_o, e.exp_type);
    check_size("mem_cmd_size_o", mem_cmd_size_o, e.exp_size);
    check_vec("mem_cmd_addr_o", 64'(mem_cmd_addr_o), 64'(e.addr));
    check_vec("mem_cmd_cce_id_o", 64'(mem_cmd_cce_id_o), 64'(e.exp_cce));
    check_vec("mem_cmd_non_excl_o", 64'(mem_cmd_non_excl_o), 64'(e.exp_non_excl));
    if (is_cached(e.kind)) begin
      if (meta_given[idx] !== 1'b1) begin
        stop_run("a cached request left before its metadata was given");
      end
      check_vec("mem_cmd_way_o", 64'(mem_cmd_way_o), 64'(e.way));
    end
    if (e.kind == uc_store) begin
      check_vec("mem_cmd_data_o", mem_cmd_data_o, e.data);
    end
  endtask

  task automatic wait_for_ready();
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (ready_o !== 1'b1) begin
      cycles++;
      if (cycles > 300) begin
        stop_run("ready_o never rose");
      end
      @(negedge clk_i);
    end
  endtask

  task automatic wait_for_full();
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (credits_full_o !== 1'b1) begin
      cycles++;
      if (cycles > 100) begin
        stop_run("credits_full_o never rose with four requests outstanding");
      end
      @(negedge clk_i);
    end
  endtask

  // all commands served and every credit handed back
  task automatic wait_for_drain(int n_cmds);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (credits_empty_o !== 1'b1 || cmd_count != n_cmds) begin
      cycles++;
      if (cycles > 1000) begin
        stop_run("outstanding requests did not drain");
      end
      @(negedge clk_i);
    end
  endtask

  task automatic apply_entry(int i);
    entry_s e;
    e = stim[i];
    wait_for_ready();
    @(posedge clk_i);
    cache_req_v_i <= 1'b1;
    cache_req_type_i <= e.kind;
    cache_req_size_i <= e.size;
    cache_req_addr_i <= e.addr;
    cache_req_data_i <= e.data;
    if (is_cached(e.kind) && e.meta_delay == 4'd0) begin
      cache_meta_v_i <= 1'b1;
      cache_meta_way_i <= e.way;
      meta_given[i] = 1'b1;
    end
    @(posedge clk_i);
    cache_req_v_i <= 1'b0;
    cache_meta_v_i <= 1'b0;
    if (is_cached(e.kind) && e.meta_delay != 4'd0) begin
      repeat (int'(e.meta_delay) - 1) @(posedge clk_i);
      cache_meta_v_i <= 1'b1;
      cache_meta_way_i <= e.way;
      meta_given[i] = 1'b1;
      @(posedge clk_i);
      cache_meta_v_i <= 1'b0;
    end
  endtask

  // memory side model with random command ready and response delay
  initial begin : responder
    logic [31:0] rnd;
    int resp_wait;
    logic taken;
    rnd = 32'd61413;
    resp_wait = -1;
    taken = 1'b0;
    mem_cmd_ready_i = 1'b0;
    mem_resp_v_i = 1'b0;
    forever begin
      @(negedge clk_i);
      taken = 1'b0;
      if (reset_i === 1'b0 && mem_cmd_v_o === 1'b1 && mem_cmd_ready_i === 1'b1) begin
        check_command(cmd_count);
        cmd_count++;
        taken = 1'b1;
      end
      @(posedge clk_i);
      rnd = xorshift(rnd);
      mem_cmd_ready_i <= ~hold_ready & rnd[0];
      mem_resp_v_i <= 1'b0;
      if (taken) begin
        resp_wait = int'(rnd[3:1]);
      end else if (resp_wait == 0) begin
        mem_resp_v_i <= 1'b1;
        resp_wait = -1;
      end else if (resp_wait > 0) begin
        resp_wait--;
      end
    end
  end

  initial begin : stimulus
    reset_i = 1'b1;
    lce_id_i = 2'd1;
    lce_mode_i = lce_mode_normal;
    sync_done_i = 1'b0;
    cache_req_type_i = miss_load;
    cache_req_size_i = msg_size_1;
    cache_req_addr_i = '0;
    cache_req_data_i = '0;
    cache_req_v_i = 1'b0;
    cache_meta_way_i = '0;
    cache_meta_v_i = 1'b0;
    for (int i = 0; i < num_entries; i++) begin
      meta_given[i] = 1'b0;
    end

    // kind, address, size, data, way, metadata delay
    stim[0] = make_entry(miss_load, 32'h0000_1040, msg_size_8, 64'h0, 3'd5, 4'd0);
    stim[1] = make_entry(miss_store, 32'h0000_2000, msg_size_8, 64'h0, 3'd2, 4'd0);
    stim[2] = make_entry(uc_store, 32'h8000_0008, msg_size_8, 64'hdead_beef_0123_4567, 3'd0, 4'd0);
    stim[3] = make_entry(uc_load, 32'h8000_0044, msg_size_4, 64'h0, 3'd0, 4'd0);
    stim[4] = make_entry(miss_load, 32'h0000_30c0, msg_size_8, 64'h0, 3'd7, 4'd5);
    stim[5] = make_entry(miss_store, 32'h0000_4040, msg_size_8, 64'h0, 3'd1, 4'd3);
    stim[6] = make_entry(uc_store, 32'h8000_0100, msg_size_2, 64'h0000_0000_0000_a55a, 3'd0, 4'd0);
    stim[7] = make_entry(miss_load, 32'h0000_5000, msg_size_8, 64'h0, 3'd3, 4'd1);
    stim[8] = make_entry(uc_load, 32'h8000_0240, msg_size_1, 64'h0, 3'd0, 4'd0);
    stim[9] = make_entry(miss_store, 32'h0000_6040, msg_size_8, 64'h0, 3'd6, 4'd0);

    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;

    // normal mode without sync keeps the handler closed
    repeat (8) begin
      @(negedge clk_i);
      check_vec("ready_o", 64'(ready_o), 64'd0);
      check_vec("mem_cmd_v_o", 64'(mem_cmd_v_o), 64'd0);
      check_vec("credits_empty_o", 64'(credits_empty_o), 64'd1);
    end
    @(posedge clk_i);
    lce_mode_i <= lce_mode_uncached;
    wait_for_ready();
    @(posedge clk_i);
    lce_mode_i <= lce_mode_normal;
    repeat (4) begin
      @(negedge clk_i);
      check_vec("ready_o", 64'(ready_o), 64'd0);
    end
    @(posedge clk_i);
    sync_done_i <= 1'b1;
    wait_for_ready();

    for (int i = 0; i < 6; i++) begin
      apply_entry(i);
    end
    wait_for_drain(6);

    // memory stalls so the credits run out
    hold_ready = 1'b1;
    for (int i = 6; i < num_entries; i++) begin
      apply_entry(i);
    end
    wait_for_full();
    repeat (5) begin
      check_vec("ready_o", 64'(ready_o), 64'd0);
      check_vec("credits_full_o", 64'(credits_full_o), 64'd1);
      check_vec("mem_cmd_v_o", 64'(mem_cmd_v_o), 64'd1);
      @(negedge clk_i);
    end
    hold_ready = 1'b0;
    wait_for_drain(num_entries);

    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
src/lce_pkg.sv
src/lce_req_if.sv
src/lce_req.sv
src/lce_req_fifo.sv
src/lce_cce_engine.sv
src/lce_top.sv
verif/tb_lce_top.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile: obj_dir/Vtb_lce_top

obj_dir/Vtb_lce_top: sim.f $(wildcard src/*.sv) $(wildcard verif/*.sv)
	verilator --binary --timing --timescale 1ns/1ps -f sim.f \
		--top-module tb_lce_top -o Vtb_lce_top

run: compile
	./obj_dir/Vtb_lce_top

clean:
	rm -rf obj_dir
